// File: logic/cpuPkg.sv
// shared widths, vector types, function enums and flag positions of the 8-bit datapath
package cpuPkg;

    localparam int dataWidth  = 8;                 // data word
    localparam int instrWidth = 16;                // instruction word
    localparam int memDepth   = 256;               // memory locations

    typedef logic [dataWidth-1:0]  byte_t;
    typedef logic [instrWidth-1:0] instr_t;
    typedef logic [3:0]            flags_t;        // {Z, C, N, V}

    localparam int flagZ = 3;                      // zero
    localparam int flagC = 2;                      // carry / not borrow
    localparam int flagN = 1;                      // negative
    localparam int flagV = 0;                      // signed overflow

    typedef logic [1:0] outSel_t;                  // read port select
    typedef logic [3:0] gprSelN_t;                 // active low, MSB is R1
    typedef logic [2:0] arfSelN_t;                 // active low, {PC, AR, SP}

    typedef enum logic [1:0] {
        regDec   = 2'd0,
        regInc   = 2'd1,
        regLoad  = 2'd2,
        regClear = 2'd3
    } regFun_t;

    typedef enum logic [3:0] {
        aluPassA, aluPassB, aluNotA, aluNotB,
        aluAdd,   aluAddC,  aluSub,  aluAnd,
        aluOr,    aluXor,   aluLsl,  aluLsr,
        aluAsl,   aluAsr,   aluRolC, aluRorC
    } aluOp_t;

    typedef enum logic [1:0] {
        muxAIr = 2'd0, muxAMem = 2'd1, muxAArfC = 2'd2, muxAAlu = 2'd3
    } muxASel_t;

    // code 0 also picks the ALU so the mux has no hole
    typedef enum logic [1:0] {
        muxBAlu0 = 2'd0, muxBIr = 2'd1, muxBMem = 2'd2, muxBAlu = 2'd3
    } muxBSel_t;

endpackage

// File: logic/loadCountReg.sv
// parameterized register with decrement, increment, load and clear functions
`timescale 1ns/1ns

module loadCountReg #(
    parameter int width = 8                          // register width
) (
    input  logic                 CLK,
    input  logic                 rstN_i,             // async, active low
    input  logic                 en_i,               // act on this edge
    input  cpuPkg::regFun_t      fun_i,              // dec / inc / load / clear
    input  logic [width-1:0]     d_i,                // load value
    output logic [width-1:0]     q_o
);

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (en_i) begin
            case (fun_i)
                cpuPkg::regDec:   q_o <= q_o - 1'b1;  // wraps at zero
                cpuPkg::regInc:   q_o <= q_o + 1'b1;  // wraps at all ones
                cpuPkg::regLoad:  q_o <= d_i;
                cpuPkg::regClear: q_o <= '0;
                default:          q_o <= q_o;
            endcase
        end
    end

    // a function code must be driven whenever the register is told to act
    funKnown: assert property (@(posedge CLK) disable iff (!rstN_i)
        en_i |-> !$isunknown(fun_i));

endmodule

// File: logic/generalRegFile.sv
// general register file R1..R4 with two combinational read ports
`timescale 1ns/1ns

module generalRegFile (
    input  logic              CLK,
    input  logic              rstN_i,
    input  cpuPkg::gprSelN_t  regSelN_i,          // active low, bit 3 is R1
    input  cpuPkg::regFun_t   fun_i,              // shared by all enabled regs
    input  cpuPkg::byte_t     d_i,                // from mux A
    input  cpuPkg::outSel_t   outASel_i,
    input  cpuPkg::outSel_t   outBSel_i,
    output cpuPkg::byte_t     outA_o,
    output cpuPkg::byte_t     outB_o
);

    cpuPkg::byte_t regQ [4];                      // index 0 is R1

    for (genvar i = 0; i < 4; i++) begin : gReg
        loadCountReg #(
            .width (cpuPkg::dataWidth)
        ) regInst (
            .CLK    (CLK),
            .rstN_i (rstN_i),
            .en_i   (~regSelN_i[3-i]),            // MSB of select maps to R1
            .fun_i  (fun_i),
            .d_i    (d_i),
            .q_o    (regQ[i])
        );
    end

    // both ports are independent, same reg may be read twice
    always_comb begin
        outA_o = regQ[outASel_i];                 // port A, ALU operand via mux C
        outB_o = regQ[outBSel_i];                 // port B, ALU operand B
    end

endmodule

// File: logic/addressRegFile.sv
// address register file holding PC, AR and SP with two read ports
`timescale 1ns/1ns

module addressRegFile (
    input  logic              CLK,
    input  logic              rstN_i,
    input  cpuPkg::arfSelN_t  regSelN_i,          // active low, {PC, AR, SP}
    input  cpuPkg::regFun_t   fun_i,
    input  cpuPkg::byte_t     d_i,                // from mux B
    input  cpuPkg::outSel_t   outCSel_i,
    input  cpuPkg::outSel_t   outDSel_i,
    output cpuPkg::byte_t     outC_o,             // to mux A and mux C
    output cpuPkg::byte_t     outD_o              // memory address
);

    cpuPkg::byte_t regQ [3];                      // 0 PC, 1 AR, 2 SP

    for (genvar i = 0; i < 3; i++) begin : gReg
        loadCountReg #(
            .width (cpuPkg::dataWidth)
        ) regInst (
            .CLK    (CLK),
            .rstN_i (rstN_i),
            .en_i   (~regSelN_i[2-i]),            // MSB is PC
            .fun_i  (fun_i),
            .d_i    (d_i),
            .q_o    (regQ[i])
        );
    end

    function automatic cpuPkg::byte_t pick(input cpuPkg::outSel_t sel);
        case (sel)
            2'd2:    return regQ[1];              // AR
            2'd3:    return regQ[2];              // SP
            default: return regQ[0];              // 0 and 1 both give PC
        endcase
    endfunction

    // reads follow both the selects and the stored registers
    always_comb begin
        outC_o = pick(outCSel_i);
        outD_o = pick(outDSel_i);
    end

endmodule

// File: logic/instructionReg.sv
// 16-bit instruction register filled one byte per load
`timescale 1ns/1ns

module instructionReg (
    input  logic              CLK,
    input  logic              rstN_i,
    input  logic              en_i,               // active high
    input  logic              lowHalf_i,          // 1 low byte, 0 high byte
    input  cpuPkg::regFun_t   fun_i,
    input  cpuPkg::byte_t     d_i,                // memory read data
    output cpuPkg::instr_t    ir_o
);

    cpuPkg::instr_t loadWord;                     // merged load value

    // keep the byte that is not being written
    assign loadWord = lowHalf_i ? {ir_o[15:8], d_i}
                                : {d_i, ir_o[7:0]};

    // inc, dec and clear work on the full word
    loadCountReg #(
        .width (cpuPkg::instrWidth)
    ) irReg (
        .CLK    (CLK),
        .rstN_i (rstN_i),
        .en_i   (en_i),
        .fun_i  (fun_i),
        .d_i    (loadWord),
        .q_o    (ir_o)
    );

endmodule

// File: logic/aluUnit.sv
// 16-function ALU with registered Z, C, N and V flags
`timescale 1ns/1ns

module aluUnit (
    input  logic              CLK,
    input  logic              rstN_i,
    input  cpuPkg::aluOp_t    op_i,
    input  cpuPkg::byte_t     a_i,                // from mux C
    input  cpuPkg::byte_t     b_i,                // general port B
    output cpuPkg::byte_t     result_o,
    output cpuPkg::flags_t    flags_o
);

    logic       cStored;                          // carry into addC and rotates
    logic [8:0] sum;                              // 9 bits to keep carry out
    logic       cNext;
    logic       vNext;
    logic       cUpd;                             // op writes C
    logic       vUpd;                             // op writes V

    assign cStored = flags_o[cpuPkg::flagC];

    always_comb begin
        sum      = '0;
        result_o = '0;
        cNext    = cStored;
        vNext    = flags_o[cpuPkg::flagV];
        cUpd     = 1'b0;
        vUpd     = 1'b0;
        case (op_i)
            cpuPkg::aluPassA: result_o = a_i;
            cpuPkg::aluPassB: result_o = b_i;     // store path to memory
            cpuPkg::aluNotA:  result_o = ~a_i;
            cpuPkg::aluNotB:  result_o = ~b_i;
            cpuPkg::aluAdd, cpuPkg::aluAddC: begin
                sum = {1'b0, a_i} + {1'b0, b_i}
                    + {8'd0, (op_i == cpuPkg::aluAddC) & cStored};
                result_o = sum[7:0];
                cNext = sum[8];
                vNext = (a_i[7] == b_i[7]) && (sum[7] != a_i[7]);  // same signs in, other out
                cUpd  = 1'b1;
                vUpd  = 1'b1;
            end
            cpuPkg::aluSub: begin
                sum = {1'b0, a_i} - {1'b0, b_i};
                result_o = sum[7:0];
                cNext = ~sum[8];                  // no borrow, A not below B
                vNext = (a_i[7] != b_i[7]) && (sum[7] != a_i[7]);
                cUpd  = 1'b1;
                vUpd  = 1'b1;
            end
            cpuPkg::aluAnd: result_o = a_i & b_i;
            cpuPkg::aluOr:  result_o = a_i | b_i;
            cpuPkg::aluXor: result_o = a_i ^ b_i;
            cpuPkg::aluLsl, cpuPkg::aluAsl: begin
                result_o = {a_i[6:0], 1'b0};
                cNext = a_i[7];                   // bit shifted out
                cUpd  = 1'b1;
                vNext = a_i[7] ^ a_i[6];          // sign changed, asl only
                vUpd  = (op_i == cpuPkg::aluAsl);
            end
            cpuPkg::aluLsr: begin
                result_o = {1'b0, a_i[7:1]};
                cNext = a_i[0];
                cUpd  = 1'b1;
            end
            cpuPkg::aluAsr: begin
                result_o = {a_i[7], a_i[7:1]};    // sign kept
                cNext = a_i[0];
                cUpd  = 1'b1;
            end
            cpuPkg::aluRolC: begin
                result_o = {a_i[6:0], cStored};   // 9-bit rotate through C
                cNext = a_i[7];
                cUpd  = 1'b1;
            end
            cpuPkg::aluRorC: begin
                result_o = {cStored, a_i[7:1]};
                cNext = a_i[0];
                cUpd  = 1'b1;
            end
            default: result_o = a_i;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            flags_o <= '0;
        end else begin
            flags_o[cpuPkg::flagZ] <= (result_o == '0);
            flags_o[cpuPkg::flagN] <= result_o[7];
            if (cUpd) flags_o[cpuPkg::flagC] <= cNext;  // others hold C
            if (vUpd) flags_o[cpuPkg::flagV] <= vNext;
        end
    end

    // an unknown operand or op anywhere upstream would surface here a cycle later
    flagsKnown: assert property (@(posedge CLK) disable iff (!rstN_i)
        !$isunknown(flags_o));

endmodule

// File: logic/dataMemory.sv
// 256-byte data memory, synchronous write and combinational read
`timescale 1ns/1ns

module dataMemory (
    input  logic           CLK,
    input  cpuPkg::byte_t  addr_i,               // from address file port D
    input  cpuPkg::byte_t  wrData_i,             // ALU result
    input  logic           wr_i,                 // 1 write, 0 read
    input  logic           csN_i,                // chip select, active low
    output cpuPkg::byte_t  rdData_o
);

    cpuPkg::byte_t mem [cpuPkg::memDepth];       // filled by stores only

    always_ff @(posedge CLK) begin
        if (wr_i && !csN_i) begin
            mem[addr_i] <= wrData_i;
        end
    end

    // deselected or writing reads zero
    assign rdData_o = (!wr_i && !csN_i) ? mem[addr_i] : '0;

    // address comes from the address file through its port D select
    addrKnown: assert property (@(posedge CLK)
        !csN_i |-> !$isunknown(addr_i));

endmodule

// File: logic/aluSystem.sv
// datapath top level with register files, IR, ALU, memory and muxes A, B, C
`timescale 1ns/1ns

module aluSystem (
    input  logic              CLK,
    input  logic              rstN_i,
    input  cpuPkg::outSel_t   rfOutASel_i,
    input  cpuPkg::outSel_t   rfOutBSel_i,
    input  cpuPkg::regFun_t   rfFun_i,
    input  cpuPkg::gprSelN_t  rfRegSelN_i,
    input  cpuPkg::aluOp_t    aluOp_i,
    input  cpuPkg::outSel_t   arfOutCSel_i,
    input  cpuPkg::outSel_t   arfOutDSel_i,
    input  cpuPkg::regFun_t   arfFun_i,
    input  cpuPkg::arfSelN_t  arfRegSelN_i,
    input  logic              irLowHalf_i,
    input  logic              irEn_i,
    input  cpuPkg::regFun_t   irFun_i,
    input  logic              memWr_i,
    input  logic              memCsN_i,
    input  cpuPkg::muxASel_t  muxASel_i,
    input  cpuPkg::muxBSel_t  muxBSel_i,
    input  logic              muxCSel_i,          // 1 general port A, 0 ARF port C
    output cpuPkg::byte_t     aluOut_o,
    output cpuPkg::flags_t    flags_o,
    output cpuPkg::byte_t     address_o,
    output cpuPkg::byte_t     memOut_o,
    output cpuPkg::instr_t    irOut_o
);

    cpuPkg::byte_t muxAOut;                       // general file input
    cpuPkg::byte_t muxBOut;                       // address file input
    cpuPkg::byte_t muxCOut;                       // ALU operand A
    cpuPkg::byte_t gprA;
    cpuPkg::byte_t gprB;
    cpuPkg::byte_t arfC;

    always_comb begin
        case (muxASel_i)
            cpuPkg::muxAIr:   muxAOut = irOut_o[7:0];  // immediate byte
            cpuPkg::muxAMem:  muxAOut = memOut_o;
            cpuPkg::muxAArfC: muxAOut = arfC;
            default:          muxAOut = aluOut_o;
        endcase
        case (muxBSel_i)
            cpuPkg::muxBIr:   muxBOut = irOut_o[7:0];
            cpuPkg::muxBMem:  muxBOut = memOut_o;
            default:          muxBOut = aluOut_o;      // codes 0 and 3
        endcase
    end

    assign muxCOut = muxCSel_i ? gprA : arfC;

    generalRegFile gprFile (
        .CLK (CLK), .rstN_i (rstN_i), .regSelN_i (rfRegSelN_i), .fun_i (rfFun_i),
        .d_i (muxAOut), .outASel_i (rfOutASel_i), .outBSel_i (rfOutBSel_i),
        .outA_o (gprA), .outB_o (gprB)
    );

    addressRegFile arFile (
        .CLK (CLK), .rstN_i (rstN_i), .regSelN_i (arfRegSelN_i), .fun_i (arfFun_i),
        .d_i (muxBOut), .outCSel_i (arfOutCSel_i), .outDSel_i (arfOutDSel_i),
        .outC_o (arfC), .outD_o (address_o)
    );

    instructionReg irUnit (
        .CLK (CLK), .rstN_i (rstN_i), .en_i (irEn_i), .lowHalf_i (irLowHalf_i),
        .fun_i (irFun_i), .d_i (memOut_o), .ir_o (irOut_o)   // fetch from memory
    );

    aluUnit alu (
        .CLK (CLK), .rstN_i (rstN_i), .op_i (aluOp_i), .a_i (muxCOut), .b_i (gprB),
        .result_o (aluOut_o), .flags_o (flags_o)
    );

    dataMemory mem (
        .CLK (CLK), .addr_i (address_o), .wrData_i (aluOut_o), .wr_i (memWr_i),
        .csN_i (memCsN_i), .rdData_o (memOut_o)
    );

endmodule

// File: dv/aluSystemTb.sv
// testbench for aluSystem with vector file reader, clock, reset, driver, checker and watchdog
`timescale 1ns/1ns

module aluSystemTb;

    logic              CLK = 1'b0;
    logic              rstN_i = 1'b0;               // held low through two edges
    cpuPkg::outSel_t   rfOutASel = '0;
    cpuPkg::outSel_t   rfOutBSel = '0;
    cpuPkg::regFun_t   rfFun = cpuPkg::regDec;
    cpuPkg::gprSelN_t  rfRegSelN = '1;              // all general regs hold
    cpuPkg::aluOp_t    aluOp = cpuPkg::aluPassA;
    cpuPkg::outSel_t   arfOutCSel = '0;
    cpuPkg::outSel_t   arfOutDSel = '0;
    cpuPkg::regFun_t   arfFun = cpuPkg::regDec;
    cpuPkg::arfSelN_t  arfRegSelN = '1;             // PC, AR, SP hold
    logic              irLowHalf = 1'b0;
    logic              irEn = 1'b0;
    cpuPkg::regFun_t   irFun = cpuPkg::regDec;
    logic              memWr = 1'b0;
    logic              memCsN = 1'b1;               // memory deselected
    cpuPkg::muxASel_t  muxASel = cpuPkg::muxAIr;
    cpuPkg::muxBSel_t  muxBSel = cpuPkg::muxBAlu0;
    logic              muxCSel = 1'b0;
    cpuPkg::byte_t     aluOut;
    cpuPkg::flags_t    flags;
    cpuPkg::byte_t     address;
    cpuPkg::byte_t     memOut;
    cpuPkg::instr_t    irOut;

    int vec [64][23];                               // 17 controls, 5 expected, mask
    int numVec = 0;
    int checks = 0;
    int valueErrors = 0;
    int otherErrors = 0;                            // file problems
    int cycles = 0;
    int cycleLimit = 20;                            // raised once the vectors are known

    aluSystem aluSystem_inst (
        .CLK (CLK), .rstN_i (rstN_i),
        .rfOutASel_i (rfOutASel), .rfOutBSel_i (rfOutBSel),
        .rfFun_i (rfFun), .rfRegSelN_i (rfRegSelN), .aluOp_i (aluOp),
        .arfOutCSel_i (arfOutCSel), .arfOutDSel_i (arfOutDSel),
        .arfFun_i (arfFun), .arfRegSelN_i (arfRegSelN),
        .irLowHalf_i (irLowHalf), .irEn_i (irEn), .irFun_i (irFun),
        .memWr_i (memWr), .memCsN_i (memCsN),
        .muxASel_i (muxASel), .muxBSel_i (muxBSel), .muxCSel_i (muxCSel),
        .aluOut_o (aluOut), .flags_o (flags), .address_o (address),
        .memOut_o (memOut), .irOut_o (irOut)
    );

    always #5 CLK = ~CLK;                           // 10 ns period

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            valueErrors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic readVectors();
        int fd;
        int n;
        string line;
        fd = $fopen("dv/testdata.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open dv/testdata.txt for reading");
        end else begin
            while (!$feof(fd) && numVec < $size(vec, 1)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments, blanks
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[numVec][0], vec[numVec][1], vec[numVec][2], vec[numVec][3],
                        vec[numVec][4], vec[numVec][5], vec[numVec][6], vec[numVec][7],
                        vec[numVec][8], vec[numVec][9], vec[numVec][10], vec[numVec][11],
                        vec[numVec][12], vec[numVec][13], vec[numVec][14], vec[numVec][15],
                        vec[numVec][16], vec[numVec][17], vec[numVec][18], vec[numVec][19],
                        vec[numVec][20], vec[numVec][21], vec[numVec][22]);
                    if (n == 23)
                        numVec++;
                    else begin
                        otherErrors++;
                        $display("malformed line in dv/testdata.txt after vector %0d", numVec);
                    end
                end
            end
            $fclose(fd);
        end
        if (numVec == 0) begin
            otherErrors++;
            $display("no test vectors were read");
        end
    endtask

    task automatic applyVector(input int i);
        rfOutASel  <= cpuPkg::outSel_t'(vec[i][0]);
        rfOutBSel  <= cpuPkg::outSel_t'(vec[i][1]);
        rfFun      <= cpuPkg::regFun_t'(vec[i][2]);
        rfRegSelN  <= cpuPkg::gprSelN_t'(vec[i][3]);
        aluOp      <= cpuPkg::aluOp_t'(vec[i][4]);
        arfOutCSel <= cpuPkg::outSel_t'(vec[i][5]);
        arfOutDSel <= cpuPkg::outSel_t'(vec[i][6]);
        arfFun     <= cpuPkg::regFun_t'(vec[i][7]);
        arfRegSelN <= cpuPkg::arfSelN_t'(vec[i][8]);
        irLowHalf  <= vec[i][9][0];
        irEn       <= vec[i][10][0];
        irFun      <= cpuPkg::regFun_t'(vec[i][11]);
        memWr      <= vec[i][12][0];
        memCsN     <= vec[i][13][0];
        muxASel    <= cpuPkg::muxASel_t'(vec[i][14]);
        muxBSel    <= cpuPkg::muxBSel_t'(vec[i][15]);
        muxCSel    <= vec[i][16][0];
    endtask

    // mask bits {aluOut, flags, address, memOut, irOut}
    task automatic checkVector(input int i);
        string tag;
        tag = $sformatf("vector %0d", i + 1);
        if (vec[i][22][4])
            compareValue({tag, " aluOut_o"}, vec[i][17][15:0], {8'h00, aluOut});
        if (vec[i][22][3])
            compareValue({tag, " flags_o"}, vec[i][18][15:0], {12'h000, flags});
        if (vec[i][22][2])
            compareValue({tag, " address_o"}, vec[i][19][15:0], {8'h00, address});
        if (vec[i][22][1])
            compareValue({tag, " memOut_o"}, vec[i][20][15:0], {8'h00, memOut});
        if (vec[i][22][0])
            compareValue({tag, " irOut_o"}, vec[i][21][15:0], irOut);
    endtask

    initial begin : watchdog
        while (cycles <= cycleLimit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", cycleLimit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        readVectors();
        cycleLimit = 4 * numVec + 20;
        repeat (2) @(posedge CLK);
        rstN_i <= 1'b1;                             // vector 1 sees the reset state
        for (int i = 0; i < numVec; i++) begin
            applyVector(i);
            @(negedge CLK);                         // outputs settled, edge not yet taken
            checkVector(i);
            @(posedge CLK);
        end
        $display("vectors %0d, checks %0d, value errors %0d, other errors %0d",
                 numVec, checks, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: dv/testdata.txt
# rfA rfB rfFun rfSelN aluOp arfC arfD arfFun arfSelN irLow irEn irFun memWr memCsN muxA muxB muxC
# then expected aluOut flags address memOut irOut and mask {alu,flags,addr,mem,ir}, all hex
0 0 0 f 0 0 0 0 7 0 0 0 0 1 0 0 1  00 0 00 00 0000 1f
0 0 2 7 2 0 0 0 7 0 0 0 0 1 3 0 0  ff 8 00 00 0000 1f
0 0 1 b 0 0 0 0 7 0 0 0 0 1 0 0 1  ff 2 00 00 0000 1f
0 1 0 d 1 0 0 0 7 0 0 0 0 1 0 0 0  01 2 00 00 0000 1f
0 1 2 e 3 0 0 0 7 0 0 0 0 1 3 0 0  fe 0 00 00 0000 1f
0 2 3 7 1 0 0 0 7 0 0 0 0 1 0 0 0  ff 2 00 00 0000 1f
0 0 1 e 0 0 0 0 7 0 0 0 0 1 0 0 1  00 2 00 00 0000 1f
0 3 0 f 1 0 0 0 7 0 0 0 0 1 0 0 0  ff 8 00 00 0000 1f
0 1 0 f 1 0 0 2 3 0 0 0 0 1 0 3 0  01 2 00 00 0000 1f
0 3 0 f 1 0 1 2 5 0 0 0 0 1 0 0 0  ff 0 01 00 0000 1f
0 1 0 f 3 0 2 2 6 0 0 0 0 1 0 3 0  fe 2 ff 00 0000 1f
0 0 0 f 0 3 3 1 6 0 0 0 0 1 0 0 0  fe 2 fe 00 0000 1f
0 0 2 7 0 1 3 0 7 0 0 0 0 1 2 0 0  01 2 ff 00 0000 1f
0 1 0 f 1 0 0 0 7 0 0 0 1 0 0 0 0  01 0 01 00 0000 1f
0 1 0 f 3 0 2 0 7 0 0 0 1 0 0 0 0  fe 0 ff 00 0000 1f
0 0 0 f 0 0 2 0 7 0 1 2 0 0 0 0 0  01 2 ff fe 0000 1f
0 0 0 f 0 0 0 0 7 1 1 2 0 0 0 0 0  01 0 01 01 fe00 1f
2 1 0 f 4 0 0 0 7 0 0 0 0 1 0 0 1  00 0 01 00 fe01 1f
2 0 2 e b 0 0 0 7 0 0 0 0 1 3 0 1  7f c 01 00 fe01 1f
3 1 0 f 4 0 0 0 7 0 0 0 0 1 0 0 1  80 4 01 00 fe01 1f
1 3 0 f 6 0 0 0 7 0 0 0 0 1 0 0 1  82 3 01 00 fe01 1f
3 1 0 f 6 0 0 0 7 0 0 0 0 1 0 0 1  7e 2 01 00 fe01 1f
2 3 0 f 7 0 0 0 7 0 0 0 0 1 0 0 1  7f 4 01 00 fe01 1f
2 3 0 f 9 0 0 0 7 0 0 0 0 1 0 0 1  80 4 01 00 fe01 1f
3 0 0 f 8 0 0 0 7 0 0 0 0 1 0 0 1  7f 6 01 00 fe01 1f
3 0 0 f c 0 0 0 7 0 0 0 0 1 0 0 1  fe 4 01 00 fe01 1f
2 0 0 f d 0 0 0 7 0 0 0 0 1 0 0 1  ff 3 01 00 fe01 1f
3 0 0 f e 0 0 0 7 0 0 0 0 1 0 0 1  ff 7 01 00 fe01 1f
1 0 0 f f 0 0 0 7 0 0 0 0 1 0 0 1  00 3 01 00 fe01 1f
1 0 0 f f 0 0 0 7 0 0 0 0 1 0 0 1  80 d 01 00 fe01 1f
1 1 0 f 5 0 0 0 7 0 0 0 0 1 0 0 1  03 7 01 00 fe01 1f
0 0 0 f 0 0 0 0 7 0 0 0 0 1 0 0 1  01 0 01 00 fe01 1f

// File: list.f
logic/cpuPkg.sv
logic/loadCountReg.sv
logic/generalRegFile.sv
logic/addressRegFile.sv
logic/instructionReg.sv
logic/aluUnit.sv
logic/dataMemory.sv
logic/aluSystem.sv
dv/aluSystemTb.sv

// File: run.sh
#!/bin/sh
verilator --binary -Wno-fatal --top-module aluSystemTb -f list.f -o simv \
    && ./obj_dir/simv > run.log 2>&1 \
    && grep -q "Done: no errors" run.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
